// ==== flist.f ====
hdl/isp_pkg.sv
hdl/isp_ctrl.sv
hdl/dram_reader.sv
hdl/exposure_scale.sv
hdl/dram_writer.sv
hdl/gray_average.sv
hdl/isp_top.sv
testbench/axi_dram_model.sv
testbench/isp_chk.sv
testbench/tb_isp.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ISP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module tb_isp -f flist.f -o sim_isp
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_isp +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0

// ==== testbench/tb_isp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_isp;

	logic                  clk;
	logic                  rst_n;
	logic                  req;
	isp_pkg::isp_req_t     req_info;
	logic                  ack;
	isp_pkg::pixel_t       result;
	isp_pkg::axi_ar_t      ar;
	logic [3:0]            arid;
	logic [7:0]            arlen;
	logic [2:0]            arsize;
	logic [1:0]            arburst;
	logic                  arready;
	isp_pkg::axi_r_t       r;
	logic                  rready;
	isp_pkg::axi_aw_t      aw;
	logic [3:0]            awid;
	logic [7:0]            awlen;
	logic [2:0]            awsize;
	logic [1:0]            awburst;
	logic                  awready;
	isp_pkg::axi_w_t       w;
	logic                  wready;
	logic                  bvalid;
	logic                  bready;

	// reference copy of DRAM and the running job
	isp_pkg::beat_t   ref_mem [16 * isp_pkg::PIC_BEATS];
	isp_pkg::beat_t   exp_beat;
	isp_pkg::pic_no_t job_pic;
	isp_pkg::ratio_t  job_ratio;
	logic [17:0]      exp_sum;
	logic             req_q;
	int               wbeat;
	int               ar_count;
	int               aw_count;
	int               cycles;
	int               wr_errors = 0;
	int               job_errors = 0;

	isp_top dut_i (.*);

	axi_dram_model mem_i (.*);

	bind isp_top isp_chk chk_i (
		.clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .ar(ar), .arready(arready),
		.rready(rready), .aw(aw), .awready(awready), .w(w), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	function automatic isp_pkg::dram_addr_t pic_addr(input isp_pkg::pic_no_t p);
		return 32'h0001_0000 + 32'(p) * 32'd3072;
	endfunction

	// x1/4, x1/2, x1, x2 clipped at 255
	function automatic isp_pkg::beat_t expect_scaled(input isp_pkg::beat_t b,
		input isp_pkg::ratio_t m);
		int p;
		isp_pkg::beat_t o;
		for (int i = 0; i < 16; i++) begin
			p = int'(b[i*8 +: 8]);
			case (m)
				2'd0: p = p / 4;
				2'd1: p = p / 2;
				2'd3: p = (p * 2 > 255) ? 255 : p * 2;
				default: ;
			endcase
			o[i*8 +: 8] = 8'(p);
		end
		return o;
	endfunction

	// green beats 64..127 count half, red and blue a quarter
	function automatic logic [17:0] gray_of(input isp_pkg::beat_t b, input int beat);
		logic [17:0] s;
		s = '0;
		for (int i = 0; i < 16; i++) begin
			if (beat >= 64 && beat < 128)
				s = s + 18'(b[i*8 +: 8] / 2);
			else
				s = s + 18'(b[i*8 +: 8] / 4);
		end
		return s;
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// bus monitor and expected values
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		req_q <= req;
		if (!rst_n) begin
			for (int i = 0; i < 16 * isp_pkg::PIC_BEATS; i++)
				ref_mem[i] <= mem_i.mem[i];
		end else if (req && !req_q) begin
			wbeat    <= 0;
			ar_count <= 0;
			aw_count <= 0;
			exp_sum  <= '0;
		end else begin
			if (ar.valid && arready) begin
				ar_count <= ar_count + 1;
				araddr_ok: assert (ar.addr == pic_addr(job_pic)) else begin
					wr_errors++;
					$display("error araddr: exp %h got %h", pic_addr(job_pic), ar.addr);
				end
				// 192 beats of 16 bytes, INCR
				arfields_ok: assert (arlen == 8'd191 && arsize == 3'd4 && arburst == 2'b01)
				else begin
					wr_errors++;
					$display("error arlen/arsize/arburst: exp %h/%h/%h got %h/%h/%h",
						8'd191, 3'd4, 2'b01, arlen, arsize, arburst);
				end
			end
			if (aw.valid && awready) begin
				aw_count <= aw_count + 1;
				awaddr_ok: assert (aw.addr == pic_addr(job_pic)) else begin
					wr_errors++;
					$display("error awaddr: exp %h got %h", pic_addr(job_pic), aw.addr);
				end
				awfields_ok: assert (awlen == 8'd191 && awsize == 3'd4 && awburst == 2'b01)
				else begin
					wr_errors++;
					$display("error awlen/awsize/awburst: exp %h/%h/%h got %h/%h/%h",
						8'd191, 3'd4, 2'b01, awlen, awsize, awburst);
				end
				// one fixed ID on both channels
				awid_ok: assert (awid == arid) else begin
					wr_errors++;
					$display("error awid: exp %h got %h", arid, awid);
				end
			end
			if (w.valid && wready) begin
				exp_beat = expect_scaled(ref_mem[int'(job_pic) * 192 + wbeat], job_ratio);
				wdata_ok: assert (w.data == exp_beat) else begin
					wr_errors++;
					$display("error wdata beat %0d: exp %h got %h", wbeat, exp_beat, w.data);
				end
				wlast_ok: assert (w.last == (wbeat == 191)) else begin
					wr_errors++;
					$display("error wlast beat %0d: exp %h got %h", wbeat, wbeat == 191, w.last);
				end
				ref_mem[int'(job_pic) * 192 + wbeat] <= exp_beat;
				exp_sum <= exp_sum + gray_of(exp_beat, wbeat);
				wbeat   <= wbeat + 1;
			end
		end
	end

	// one four-phase job on the host port
	task automatic run_job(input isp_pkg::pic_no_t pic, input isp_pkg::ratio_t mode);
		logic [7:0] exp_result;
		@(posedge clk);
		job_pic   <= pic;
		job_ratio <= mode;
		req       <= 1'b1;
		req_info  <= '{pic_no: pic, ratio: mode};
		@(posedge clk);
		while (!ack)
			@(posedge clk);
		exp_result = exp_sum[17:10];
		result_ok: assert (result == exp_result) else begin
			job_errors++;
			$display("error result pic %0d: exp %h got %h", pic, exp_result, result);
		end
		counts_ok: assert (wbeat == 192 && ar_count == 1 && aw_count == 1) else begin
			job_errors++;
			$display("picture %0d job saw %0d write beats, %0d read and %0d write addresses",
				pic, wbeat, ar_count, aw_count);
		end
		req <= 1'b0;
		@(posedge clk);
		while (ack)
			@(posedge clk);
	endtask

	initial begin
		req      = 1'b0;
		req_info = '0;
		rst_n    = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// every ratio once, then two pictures that were already scaled
		run_job(4'd3, 2'd0);
		run_job(4'd7, 2'd1);
		run_job(4'd0, 2'd2);
		run_job(4'd15, 2'd3);
		run_job(4'd3, 2'd3);
		run_job(4'd15, 2'd1);
		@(posedge clk);
		$display("errors: %0d bus, %0d job, %0d protocol", wr_errors, job_errors,
			dut_i.chk_i.fails);
		if (wr_errors + job_errors + dut_i.chk_i.fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// 8 jobs of 192 beats at 4 cycles each
	initial begin
		cycles = 0;
		while (cycles < 8 * isp_pkg::PIC_BEATS * 4) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a job never finished", cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/isp_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_chk (
	input wire                   clk,
	input wire                   rst_n,
	input wire                   req,
	input wire                   ack,
	input wire isp_pkg::axi_ar_t ar,
	input wire                   arready,
	input wire                   rready,
	input wire isp_pkg::axi_aw_t aw,
	input wire                   awready,
	input wire isp_pkg::axi_w_t  w,
	input wire                   wready,
	input wire                   bvalid,
	input wire                   bready
);

	int fails = 0;

	// ------------------------------------------------------------------
	// host handshake
	// ------------------------------------------------------------------
	idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |->
		!ack && !ar.valid && !rready && !aw.valid && !w.valid && !bready)
	else begin
		fails++;
		$error("handshake outputs not low after reset");
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
	else begin
		fails++;
		$error("ack rose while req was low");
	end

	// ack only falls once req has gone
	ack_held: assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
	else begin
		fails++;
		$error("ack dropped while req was still high");
	end

	// ------------------------------------------------------------------
	// AXI channels
	// ------------------------------------------------------------------
	ar_held: assert property (@(posedge clk) disable iff (!rst_n)
		ar.valid && !arready |=> ar.valid && $stable(ar.addr))
	else begin
		fails++;
		$error("read address withdrawn before arready");
	end

	aw_held: assert property (@(posedge clk) disable iff (!rst_n)
		aw.valid && !awready |=> aw.valid && $stable(aw.addr))
	else begin
		fails++;
		$error("write address withdrawn before awready");
	end

	w_held: assert property (@(posedge clk) disable iff (!rst_n)
		w.valid && !wready |=> w.valid && $stable(w.data) && $stable(w.last))
	else begin
		fails++;
		$error("write beat changed while stalled");
	end

	b_held: assert property (@(posedge clk) disable iff (!rst_n) bready && !bvalid |=> bready)
	else begin
		fails++;
		$error("bready dropped before bvalid");
	end

endmodule

`default_nettype wire

// ==== testbench/axi_dram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_dram_model (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire isp_pkg::axi_ar_t ar,
	output logic                  arready,
	output isp_pkg::axi_r_t       r,
	input  wire                   rready,
	input  wire isp_pkg::axi_aw_t aw,
	output logic                  awready,
	input  wire isp_pkg::axi_w_t  w,
	output logic                  wready,
	output logic                  bvalid,
	input  wire                   bready
);

	// pictures 0..15, one beat per entry
	isp_pkg::beat_t mem [16 * isp_pkg::PIC_BEATS];

	logic        rd_busy;
	logic        wr_busy;
	logic        rvalid;
	logic [11:0] rd_ptr;
	logic [11:0] wr_ptr;
	logic [7:0]  rd_cnt;
	logic [31:0] rnd;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [11:0] beat_of(input isp_pkg::dram_addr_t a);
		isp_pkg::dram_addr_t off;
		off = (a - isp_pkg::DRAM_BASE) >> 4;
		return off[11:0];
	endfunction

	// ------------------------------------------------------------------
	// memory contents, then write beats as they arrive
	// ------------------------------------------------------------------
	initial begin
		logic [31:0] fill;
		fill = 32'd29012;
		for (int i = 0; i < 16 * isp_pkg::PIC_BEATS; i++) begin
			for (int k = 0; k < 4; k++) begin
				fill = xorshift(fill);
				mem[i][k*32 +: 32] = fill;
			end
		end
		forever begin
			@(posedge clk);
			if (w.valid && wready)
				mem[wr_ptr] = w.data;
		end
	end

	// stall source
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rnd <= 32'd29012;
		else
			rnd <= xorshift(rnd);
	end

	// ------------------------------------------------------------------
	// read channel, a beat stays valid until it is taken
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			rvalid  <= 1'b0;
			rd_ptr  <= '0;
			rd_cnt  <= '0;
		end else begin
			if (ar.valid && arready) begin
				rd_busy <= 1'b1;
				rd_ptr  <= beat_of(ar.addr);
				rd_cnt  <= '0;
			end
			if (rvalid && rready) begin
				rd_ptr <= rd_ptr + 12'd1;
				rd_cnt <= rd_cnt + 8'd1;
				if (r.last)
					rd_busy <= 1'b0;
			end
			if (!rvalid || rready)
				rvalid <= rd_busy && !(rvalid && r.last) && (rnd[1:0] != 2'b00);
		end
	end

	assign arready = !rd_busy && (rnd[5:4] != 2'b00);
	assign r = '{data: mem[rd_ptr], last: rd_cnt == 8'(isp_pkg::PIC_BEATS - 1), valid: rvalid};

	// ------------------------------------------------------------------
	// write channel and response
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_busy <= 1'b0;
			wr_ptr  <= '0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			wready <= rnd[9:8] != 2'b00;
			if (aw.valid && awready) begin
				wr_busy <= 1'b1;
				wr_ptr  <= beat_of(aw.addr);
			end
			if (w.valid && wready) begin
				wr_ptr <= wr_ptr + 12'd1;
				if (w.last) begin
					wr_busy <= 1'b0;
					bvalid  <= 1'b1;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	assign awready = !wr_busy && !bvalid && (rnd[7:6] != 2'b00);

endmodule

`default_nettype wire

// ==== hdl/isp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_top (
	input  wire                    clk,
	input  wire                    rst_n,
	// host port
	input  wire                    req,
	input  wire isp_pkg::isp_req_t req_info,
	output logic                   ack,
	output isp_pkg::pixel_t        result,
	// read address / data
	output isp_pkg::axi_ar_t       ar,
	output logic [3:0]             arid,
	output logic [7:0]             arlen,
	output logic [2:0]             arsize,
	output logic [1:0]             arburst,
	input  wire                    arready,
	input  wire isp_pkg::axi_r_t   r,
	output logic                   rready,
	// write address / data / response
	output isp_pkg::axi_aw_t       aw,
	output logic [3:0]             awid,
	output logic [7:0]             awlen,
	output logic [2:0]             awsize,
	output logic [1:0]             awburst,
	input  wire                    awready,
	output isp_pkg::axi_w_t        w,
	input  wire                    wready,
	input  wire                    bvalid,
	output logic                   bready
);

	logic                  start;
	logic                  wr_done;
	isp_pkg::dram_addr_t   base_addr;
	isp_pkg::ratio_t       ratio;
	isp_pkg::beat_stream_t s_read;
	isp_pkg::beat_stream_t s_scaled;
	logic                  rd_ready;
	logic                  wr_ready;

	// burst shape never changes
	assign arid    = isp_pkg::AXI_ID;
	assign arlen   = isp_pkg::AXI_LEN;
	assign arsize  = isp_pkg::AXI_SIZE;
	assign arburst = isp_pkg::AXI_BURST;
	assign awid    = isp_pkg::AXI_ID;
	assign awlen   = isp_pkg::AXI_LEN;
	assign awsize  = isp_pkg::AXI_SIZE;
	assign awburst = isp_pkg::AXI_BURST;

	isp_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n), .req(req), .req_info(req_info), .ack(ack),
		.start(start), .base_addr(base_addr), .ratio(ratio), .wr_done(wr_done)
	);

	dram_reader reader_i (
		.clk(clk), .rst_n(rst_n), .start(start), .base_addr(base_addr),
		.ar(ar), .arready(arready), .r(r), .rready(rready),
		.s_read(s_read), .rd_ready(rd_ready)
	);

	exposure_scale scale_i (
		.clk(clk), .rst_n(rst_n), .ratio(ratio), .s_read(s_read),
		.rd_ready(rd_ready), .s_scaled(s_scaled), .wr_ready(wr_ready)
	);

	dram_writer writer_i (
		.clk(clk), .rst_n(rst_n), .start(start), .base_addr(base_addr),
		.aw(aw), .awready(awready), .w(w), .wready(wready), .bvalid(bvalid),
		.bready(bready), .s_scaled(s_scaled), .wr_ready(wr_ready), .wr_done(wr_done)
	);

	gray_average gray_i (
		.clk(clk), .rst_n(rst_n), .start(start), .s_scaled(s_scaled),
		.wr_ready(wr_ready), .result(result)
	);

endmodule

`default_nettype wire

// ==== hdl/gray_average.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_average (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire isp_pkg::beat_stream_t s_scaled,
	input  wire                        wr_ready,
	output isp_pkg::pixel_t            result
);

	isp_pkg::gray_sum_t sum;
	isp_pkg::gray_sum_t beat_sum;
	logic               green;
	logic [1:0]         shift;

	// beats 64..127 carry the green channel
	assign green = s_scaled.idx >= isp_pkg::beat_idx_t'(isp_pkg::CH_BEATS) &&
		s_scaled.idx < isp_pkg::beat_idx_t'(2 * isp_pkg::CH_BEATS);

	// green weighs 1/2, red and blue 1/4
	assign shift = green ? 2'd1 : 2'd2;

	always_comb begin
		beat_sum = '0;
		for (int i = 0; i < isp_pkg::PIX_PER_BEAT; i++)
			beat_sum = beat_sum + isp_pkg::gray_sum_t'(s_scaled.data[i*8 +: 8] >> shift);
	end

	// ------------------------------------------------------------------
	// accumulate over accepted write beats
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sum <= '0;
		else if (start)
			sum <= '0;
		else if (s_scaled.valid && wr_ready)
			sum <= sum + beat_sum;
	end

	// divide by 1024 for the mean
	assign result = sum[17:10];

endmodule

`default_nettype wire

// ==== hdl/dram_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_writer (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire isp_pkg::dram_addr_t   base_addr,
	output isp_pkg::axi_aw_t           aw,
	input  wire                        awready,
	output isp_pkg::axi_w_t            w,
	input  wire                        wready,
	input  wire                        bvalid,
	output logic                       bready,
	input  wire isp_pkg::beat_stream_t s_scaled,
	output logic                       wr_ready,
	output logic                       wr_done
);

	logic awvalid;
	logic wr_active;
	logic wvalid;
	logic wlast;
	logic w_fire;

	assign wvalid = wr_active && s_scaled.valid;
	assign wlast  = s_scaled.idx == isp_pkg::beat_idx_t'(isp_pkg::PIC_BEATS - 1);
	assign w_fire = wvalid && wready;

	// ------------------------------------------------------------------
	// write address
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			awvalid <= 1'b0;
		else if (start)
			awvalid <= 1'b1;
		else if (awvalid && awready)
			awvalid <= 1'b0;
	end

	// ------------------------------------------------------------------
	// write data, open from address accept until the last beat
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_active <= 1'b0;
		else if (awvalid && awready)
			wr_active <= 1'b1;
		else if (w_fire && wlast)
			wr_active <= 1'b0;
	end

	// response, held until the slave answers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bready <= 1'b0;
		else if (awvalid && awready)
			bready <= 1'b1;
		else if (bvalid)
			bready <= 1'b0;
	end

	assign aw       = '{addr: base_addr, valid: awvalid};
	assign w        = '{data: s_scaled.data, last: wlast, valid: wvalid};
	assign wr_ready = wr_active && wready;
	assign wr_done  = bvalid && bready;

endmodule

`default_nettype wire

// ==== hdl/exposure_scale.sv ====
`timescale 1ns/1ps
`default_nettype none

module exposure_scale (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire isp_pkg::ratio_t        ratio,
	input  wire isp_pkg::beat_stream_t  s_read,
	output logic                        rd_ready,
	output isp_pkg::beat_stream_t       s_scaled,
	input  wire                         wr_ready
);

	logic               out_valid;
	isp_pkg::beat_t     out_data;
	isp_pkg::beat_idx_t out_idx;
	isp_pkg::beat_t     scaled;

	// x0.25, x0.5, x1, x2 with saturation
	function automatic isp_pkg::pixel_t scale_pix(input isp_pkg::pixel_t p,
		input isp_pkg::ratio_t mode);
		case (mode)
			2'd0:    scale_pix = p >> 2;
			2'd1:    scale_pix = p >> 1;
			2'd2:    scale_pix = p;
			default: scale_pix = p[7] ? 8'hff : {p[6:0], 1'b0};
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < isp_pkg::PIX_PER_BEAT; i++)
			scaled[i*8 +: 8] = scale_pix(s_read.data[i*8 +: 8], ratio);
	end

	// take a new beat when empty or when the held one leaves
	assign rd_ready = !out_valid || wr_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (s_read.valid && rd_ready)
			out_valid <= 1'b1;
		else if (wr_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (s_read.valid && rd_ready) begin
			out_data <= scaled;
			out_idx  <= s_read.idx;
		end
	end

	assign s_scaled = '{valid: out_valid, data: out_data, idx: out_idx};

endmodule

`default_nettype wire

// ==== hdl/dram_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_reader (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      start,
	input  wire isp_pkg::dram_addr_t base_addr,
	output isp_pkg::axi_ar_t         ar,
	input  wire                      arready,
	input  wire isp_pkg::axi_r_t     r,
	output logic                     rready,
	output isp_pkg::beat_stream_t    s_read,
	input  wire                      rd_ready
);

	logic               arvalid;
	logic               rd_active;
	logic               r_fire;
	isp_pkg::beat_idx_t idx;

	assign r_fire = r.valid && rready;

	// address phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			arvalid <= 1'b0;
		else if (start)
			arvalid <= 1'b1;
		else if (arvalid && arready)
			arvalid <= 1'b0;
	end

	// data phase runs from address accept to the beat with last
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_active <= 1'b0;
		else if (arvalid && arready)
			rd_active <= 1'b1;
		else if (r_fire && r.last)
			rd_active <= 1'b0;
	end

	// beat number inside the burst
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (start)
			idx <= '0;
		else if (r_fire)
			idx <= idx + 1'b1;
	end

	assign ar     = '{addr: base_addr, valid: arvalid};
	assign rready = rd_active && rd_ready;
	assign s_read = '{valid: rd_active && r.valid, data: r.data, idx: idx};

endmodule

`default_nettype wire

// ==== hdl/isp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_ctrl (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    req,
	input  wire isp_pkg::isp_req_t req_info,
	output logic                   ack,
	output logic                   start,
	output isp_pkg::dram_addr_t    base_addr,
	output isp_pkg::ratio_t        ratio,
	input  wire                    wr_done
);

	isp_pkg::job_state_t state;
	isp_pkg::isp_req_t   job;

	// ------------------------------------------------------------------
	// job FSM and host handshake
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= isp_pkg::IDLE;
			start <= 1'b0;
			ack   <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				isp_pkg::IDLE: begin
					if (req) begin
						start <= 1'b1;
						state <= isp_pkg::RUN;
					end
				end
				isp_pkg::RUN: begin
					if (wr_done)
						state <= isp_pkg::WAIT_DONE;
				end
				isp_pkg::WAIT_DONE: begin
					// last sum update has landed by now
					ack   <= 1'b1;
					state <= isp_pkg::RESPOND;
				end
				isp_pkg::RESPOND: begin
					// hold ack until the host lets go of req
					if (!req) begin
						ack   <= 1'b0;
						state <= isp_pkg::IDLE;
					end
				end
				default: state <= isp_pkg::IDLE;
			endcase
		end
	end

	// request is stable while req is high
	always_ff @(posedge clk) begin
		if (state == isp_pkg::IDLE && req)
			job <= req_info;
	end

	// picture n sits at base + n * 3072
	assign base_addr = isp_pkg::DRAM_BASE +
		isp_pkg::dram_addr_t'(job.pic_no) * isp_pkg::PIC_BYTES;
	assign ratio = job.ratio;

endmodule

`default_nettype wire

// ==== hdl/isp_pkg.sv ====
`default_nettype none

package isp_pkg;

	// ------------------------------------------------------------------
	// picture geometry, fixed by the DRAM layout
	// ------------------------------------------------------------------
	localparam int PIX_PER_BEAT = 16;
	localparam int CH_BEATS     = 64;
	localparam int PIC_BEATS    = 3 * CH_BEATS;

	typedef logic [7:0]                  pixel_t;
	typedef logic [8*PIX_PER_BEAT-1:0]   beat_t;
	typedef logic [7:0]                  beat_idx_t;
	typedef logic [3:0]                  pic_no_t;
	typedef logic [1:0]                  ratio_t;
	typedef logic [31:0]                 dram_addr_t;
	typedef logic [17:0]                 gray_sum_t;

	// one picture is 192 beats of 16 bytes
	localparam dram_addr_t PIC_BYTES = dram_addr_t'(PIC_BEATS * PIX_PER_BEAT);
	localparam dram_addr_t DRAM_BASE = 32'h0001_0000;

	// constant burst fields, one 192-beat INCR burst of 16-byte beats
	localparam logic [3:0] AXI_ID    = 4'd0;
	localparam logic [7:0] AXI_LEN   = 8'(PIC_BEATS - 1);
	localparam logic [2:0] AXI_SIZE  = 3'b100;
	localparam logic [1:0] AXI_BURST = 2'b01;

	// ------------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------------
	typedef struct packed {
		pic_no_t pic_no;
		ratio_t  ratio;
	} isp_req_t;

	// stream between pipeline stages, ready runs the other way
	typedef struct packed {
		logic      valid;
		beat_t     data;
		beat_idx_t idx;
	} beat_stream_t;

	typedef struct packed {
		dram_addr_t addr;
		logic       valid;
	} axi_ar_t;

	typedef struct packed {
		dram_addr_t addr;
		logic       valid;
	} axi_aw_t;

	typedef struct packed {
		beat_t data;
		logic  last;
		logic  valid;
	} axi_r_t;

	typedef struct packed {
		beat_t data;
		logic  last;
		logic  valid;
	} axi_w_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		WAIT_DONE,
		RESPOND
	} job_state_t;

endpackage

`default_nettype wire
